/* source/clkPkg.sv */
/* Shared widths, diagnostic function codes, structs and the run-state enum
   for the clock board; modules refer to these by scoped name */
package clkPkg;

  typedef logic [2:0] diagFuncT;
  typedef logic [3:0] diagDataT;
  typedef logic [7:0] burstCountT;
  typedef logic [1:0] rateSelT;
  typedef logic [1:0] cramTimeT;
  typedef logic [5:0] readWordT;
  typedef logic [2:0] rateDivT;
  typedef logic [2:0] cycleTimerT;

  // Control functions (00x)
  localparam diagFuncT fnStop       = 3'd0;
  localparam diagFuncT fnStart      = 3'd1;
  localparam diagFuncT fnSingleStep = 3'd2;
  localparam diagFuncT fnBurst      = 3'd5;
  localparam diagFuncT fnClrReset   = 3'd6;
  localparam diagFuncT fnSetReset   = 3'd7;

  // Load functions (04x)
  localparam diagFuncT fnLdBurstLsb = 3'd2;
  localparam diagFuncT fnLdBurstMsb = 3'd3;
  localparam diagFuncT fnLdRate     = 3'd4;
  localparam diagFuncT fnLdEboxDis  = 3'd5;

  // Readback selects
  localparam diagFuncT rdBurst = 3'd0;
  localparam diagFuncT rdRun   = 3'd1;
  localparam diagFuncT rdEbox  = 3'd2;

  // Shortest EBOX cycle in ticks
  localparam cycleTimerT cycleBase = 3'd2;

  typedef struct packed {
    logic     start;
    logic     stop;
    logic     singleStep;
    logic     burst;
    logic     ldBurstLsb;
    logic     ldBurstMsb;
    diagDataT data;
  } diagCmdT;

  typedef struct packed {
    rateSelT rateSel;
    logic    crmDis;
    logic    edpDis;
    logic    ctlDis;
  } clkCfgT;

  typedef enum logic [1:0] {
    runIdle,
    runGo,
    runBurst,
    runStep
  } runStateT;

endpackage

/* source/clkDiagFunc.sv */
/* Diagnostic function decoder: turns control and load strobes into command
   pulses and keeps the rate, section-disable and machine-reset registers */
`timescale 1ns/1ps

module clkDiagFunc (
  input  logic              CLK,
  input  logic              rstN,
  input  clkPkg::diagFuncT  diagFunc,
  input  logic              diagCtl,
  input  logic              diagLd,
  input  clkPkg::diagDataT  ebusData,
  output clkPkg::diagCmdT   cmd,
  output clkPkg::clkCfgT    cfg,
  output logic              mrReset
);

  // Command pulses follow the strobe in the same cycle
  always_comb begin
    cmd = '0;
    cmd.data = ebusData;
    if (diagCtl) begin
      case (diagFunc)
        clkPkg::fnStop:       cmd.stop = 1'b1;
        clkPkg::fnStart:      cmd.start = 1'b1;
        clkPkg::fnSingleStep: cmd.singleStep = 1'b1;
        clkPkg::fnBurst:      cmd.burst = 1'b1;
        default: ;
      endcase
    end
    if (diagLd) begin
      case (diagFunc)
        clkPkg::fnLdBurstLsb: cmd.ldBurstLsb = 1'b1;
        clkPkg::fnLdBurstMsb: cmd.ldBurstMsb = 1'b1;
        default: ;
      endcase
    end
  end

  // Machine reset comes up set and is cleared by software
  always_ff @(posedge CLK) begin
    if (!rstN) begin
      mrReset <= 1'b1;
    end else if (diagCtl) begin
      if (diagFunc == clkPkg::fnSetReset) begin
        mrReset <= 1'b1;
      end else if (diagFunc == clkPkg::fnClrReset) begin
        mrReset <= 1'b0;
      end
    end
  end

  // Rate uses the low two data bits, disables use bits 2..0
  always_ff @(posedge CLK) begin
    if (!rstN) begin
      cfg <= '0;
    end else if (diagLd) begin
      case (diagFunc)
        clkPkg::fnLdRate: begin
          cfg.rateSel <= ebusData[1:0];
        end
        clkPkg::fnLdEboxDis: begin
          cfg.crmDis <= ebusData[2];
          cfg.edpDis <= ebusData[1];
          cfg.ctlDis <= ebusData[0];
        end
        default: ;
      endcase
    end
  end

endmodule

/* source/clkRunGate.sv */
/* Run gate: rate divider, run-mode FSM and burst counter; emits the one-cycle
   clkTick enable that stands in for the gated board clock */
`timescale 1ns/1ps

module clkRunGate (
  input  logic                CLK,
  input  logic                rstN,
  input  clkPkg::diagCmdT     cmd,
  input  clkPkg::rateSelT     rateSel,
  output logic                clkTick,
  output clkPkg::runStateT    runState,
  output clkPkg::burstCountT  burstCount
);

  clkPkg::rateDivT rateDiv;
  logic            rateStrobe;
  logic            burstZero;

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      rateDiv <= '0;
    end else begin
      rateDiv <= rateDiv + 3'd1;
    end
  end

  // One strobe every 1, 2, 4 or 8 cycles
  always_comb begin
    case (rateSel)
      2'd0:    rateStrobe = 1'b1;
      2'd1:    rateStrobe = (rateDiv[0] == 1'b0);
      2'd2:    rateStrobe = (rateDiv[1:0] == 2'b00);
      default: rateStrobe = (rateDiv == 3'b000);
    endcase
  end

  assign burstZero = (burstCount == '0);

  assign clkTick = rateStrobe &
                   ((runState == clkPkg::runGo) |
                    ((runState == clkPkg::runBurst) & ~burstZero) |
                    (runState == clkPkg::runStep));

  // Commands override whatever the current mode is doing
  always_ff @(posedge CLK) begin
    if (!rstN) begin
      runState <= clkPkg::runIdle;
    end else if (cmd.stop) begin
      runState <= clkPkg::runIdle;
    end else if (cmd.start) begin
      runState <= clkPkg::runGo;
    end else if (cmd.burst) begin
      runState <= clkPkg::runBurst;
    end else if (cmd.singleStep) begin
      runState <= clkPkg::runStep;
    end else begin
      case (runState)
        clkPkg::runStep: if (clkTick) runState <= clkPkg::runIdle;
        clkPkg::runBurst: if (burstZero) runState <= clkPkg::runIdle;
        default: ;
      endcase
    end
  end

  // Nibble loads, else count down one per burst tick
  always_ff @(posedge CLK) begin
    if (!rstN) begin
      burstCount <= '0;
    end else if (cmd.ldBurstLsb) begin
      burstCount[3:0] <= cmd.data;
    end else if (cmd.ldBurstMsb) begin
      burstCount[7:4] <= cmd.data;
    end else if (clkTick && runState == clkPkg::runBurst) begin
      burstCount <= burstCount - 8'd1;
    end
  end

endmodule

/* source/clkEboxCycle.sv */
/* EBOX cycle timer: spaces EBOX clocks by cramTime plus the base tick count
   and gates the CRM, EDP and CTL section clocks by their disable bits */
`timescale 1ns/1ps

module clkEboxCycle (
  input  logic                CLK,
  input  logic                rstN,
  input  logic                clkTick,
  input  clkPkg::cramTimeT    cramTime,
  input  logic                mrReset,
  input  clkPkg::clkCfgT      cfg,
  output logic                eboxClk,
  output logic                crmClk,
  output logic                edpClk,
  output logic                ctlClk,
  output clkPkg::cycleTimerT  cycleTimer
);

  clkPkg::cycleTimerT eboxLimit;
  clkPkg::cycleTimerT timerNext;
  logic               cycleDone;

  assign eboxLimit = {1'b0, cramTime} + clkPkg::cycleBase;
  assign timerNext = cycleTimer + 3'd1;

  // Last tick of the cycle, suppressed while the machine is in reset
  assign cycleDone = clkTick & ~mrReset & (timerNext == eboxLimit);

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      cycleTimer <= '0;
    end else if (mrReset || cycleDone) begin
      cycleTimer <= '0;
    end else if (clkTick) begin
      cycleTimer <= timerNext;
    end
  end

  // Section clocks share the register stage with eboxClk
  always_ff @(posedge CLK) begin
    if (!rstN) begin
      eboxClk <= 1'b0;
      crmClk  <= 1'b0;
      edpClk  <= 1'b0;
      ctlClk  <= 1'b0;
    end else begin
      eboxClk <= cycleDone;
      crmClk  <= cycleDone & ~cfg.crmDis;
      edpClk  <= cycleDone & ~cfg.edpDis;
      ctlClk  <= cycleDone & ~cfg.ctlDis;
    end
  end

endmodule

/* source/clkDiagRead.sv */
/* Diagnostic readback: on a read strobe, registers the status word chosen
   by diagFunc for one cycle; the word is zero when readValid is low */
`timescale 1ns/1ps

module clkDiagRead (
  input  logic                CLK,
  input  logic                rstN,
  input  logic                diagRead,
  input  clkPkg::diagFuncT    diagFunc,
  input  clkPkg::burstCountT  burstCount,
  input  clkPkg::runStateT    runState,
  input  clkPkg::clkCfgT      cfg,
  input  logic                mrReset,
  input  clkPkg::cycleTimerT  cycleTimer,
  output clkPkg::readWordT    readData,
  output logic                readValid
);

  clkPkg::readWordT readWord;

  always_comb begin
    case (diagFunc)
      clkPkg::rdBurst: readWord = burstCount[7:2];
      clkPkg::rdRun:   readWord = {burstCount[1:0], cfg.rateSel,
                                   runState == clkPkg::runGo,
                                   runState == clkPkg::runBurst};
      clkPkg::rdEbox:  readWord = {mrReset, cfg.crmDis, cfg.edpDis, cfg.ctlDis,
                                   cycleTimer[1:0]};
      default:         readWord = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      readValid <= 1'b0;
      readData  <= '0;
    end else begin
      readValid <= diagRead;
      readData  <= diagRead ? readWord : '0;
    end
  end

endmodule

/* source/clkBoard.sv */
/* Clock board top: decoder feeds the run gate, which ticks the EBOX cycle
   timer; the readback block samples state from all three */
`timescale 1ns/1ps

module clkBoard (
  input  logic              CLK,
  input  logic              rstN,
  input  clkPkg::diagFuncT  diagFunc,
  input  logic              diagCtl,
  input  logic              diagLd,
  input  logic              diagRead,
  input  clkPkg::diagDataT  ebusData,
  input  clkPkg::cramTimeT  cramTime,
  output logic              clkTick,
  output logic              eboxClk,
  output logic              crmClk,
  output logic              edpClk,
  output logic              ctlClk,
  output clkPkg::readWordT  readData,
  output logic              readValid
);

  clkPkg::diagCmdT    cmd;
  clkPkg::clkCfgT     cfg;
  logic               mrReset;
  clkPkg::runStateT   runState;
  clkPkg::burstCountT burstCount;
  clkPkg::cycleTimerT cycleTimer;

  clkDiagFunc diagFunc0 (
    .CLK(CLK), .rstN(rstN),
    .diagFunc(diagFunc), .diagCtl(diagCtl), .diagLd(diagLd),
    .ebusData(ebusData),
    .cmd(cmd), .cfg(cfg), .mrReset(mrReset)
  );

  clkRunGate runGate0 (
    .CLK(CLK), .rstN(rstN),
    .cmd(cmd), .rateSel(cfg.rateSel),
    .clkTick(clkTick), .runState(runState), .burstCount(burstCount)
  );

  clkEboxCycle eboxCycle0 (
    .CLK(CLK), .rstN(rstN),
    .clkTick(clkTick), .cramTime(cramTime), .mrReset(mrReset), .cfg(cfg),
    .eboxClk(eboxClk), .crmClk(crmClk), .edpClk(edpClk), .ctlClk(ctlClk),
    .cycleTimer(cycleTimer)
  );

  clkDiagRead diagRead0 (
    .CLK(CLK), .rstN(rstN),
    .diagRead(diagRead), .diagFunc(diagFunc),
    .burstCount(burstCount), .runState(runState), .cfg(cfg),
    .mrReset(mrReset), .cycleTimer(cycleTimer),
    .readData(readData), .readValid(readValid)
  );

endmodule

/* sim/clkBoardModel.svh */
/* Cycle model of the clock board, included inside the testbench module;
   modelEdge advances every mirrored register by one clock edge */

clkPkg::rateDivT    mRateDiv;
clkPkg::runStateT   mState;
clkPkg::burstCountT mCount;
clkPkg::clkCfgT     mCfg;
logic               mReset;
clkPkg::cycleTimerT mTimer;
logic [3:0]         mClocks;
logic               mValid;
clkPkg::readWordT   mData;

// Tick when the low rateSel bits of the divider are zero and the mode allows it
function automatic logic modelTick();
  logic strobe;
  strobe = (mRateDiv & ((3'd1 << mCfg.rateSel) - 3'd1)) == 3'd0;
  return strobe && (mState == clkPkg::runGo || mState == clkPkg::runStep ||
                    (mState == clkPkg::runBurst && mCount != 8'd0));
endfunction

function automatic clkPkg::readWordT modelWord(input clkPkg::diagFuncT sel);
  case (sel)
    clkPkg::rdBurst: return mCount[7:2];
    clkPkg::rdRun:   return {mCount[1:0], mCfg.rateSel, mState == clkPkg::runGo,
                             mState == clkPkg::runBurst};
    clkPkg::rdEbox:  return {mReset, mCfg.crmDis, mCfg.edpDis, mCfg.ctlDis, mTimer[1:0]};
    default:         return 6'd0;
  endcase
endfunction

task automatic modelReset();
  mRateDiv = '0;
  mState = clkPkg::runIdle;
  mCount = '0;
  mCfg = '0;
  mReset = 1'b1;
  mTimer = '0;
  mClocks = '0;
  mValid = 1'b0;
  mData = '0;
endtask

task automatic modelEdge();
  logic               tick;
  logic               done;
  clkPkg::cycleTimerT timerNext;
  clkPkg::runStateT   nextState;
  tick = modelTick();
  timerNext = mTimer + 3'd1;
  // An EBOX cycle closes on its cramTime+2 tick
  done = tick && !mReset && (timerNext == ({1'b0, cramTime} + clkPkg::cycleBase));
  mData = diagRead ? modelWord(diagFunc) : 6'd0;
  mValid = diagRead;
  mClocks = {done, done && !mCfg.crmDis, done && !mCfg.edpDis, done && !mCfg.ctlDis};
  if (mReset || done) mTimer = '0;
  else if (tick) mTimer = timerNext;
  nextState = mState;
  if (diagCtl && diagFunc == clkPkg::fnStop) nextState = clkPkg::runIdle;
  else if (diagCtl && diagFunc == clkPkg::fnStart) nextState = clkPkg::runGo;
  else if (diagCtl && diagFunc == clkPkg::fnBurst) nextState = clkPkg::runBurst;
  else if (diagCtl && diagFunc == clkPkg::fnSingleStep) nextState = clkPkg::runStep;
  else if (mState == clkPkg::runStep && tick) nextState = clkPkg::runIdle;
  else if (mState == clkPkg::runBurst && mCount == 8'd0) nextState = clkPkg::runIdle;
  if (diagLd && diagFunc == clkPkg::fnLdBurstLsb) mCount[3:0] = ebusData;
  else if (diagLd && diagFunc == clkPkg::fnLdBurstMsb) mCount[7:4] = ebusData;
  else if (tick && mState == clkPkg::runBurst) mCount = mCount - 8'd1;
  mState = nextState;
  if (diagCtl && diagFunc == clkPkg::fnSetReset) mReset = 1'b1;
  else if (diagCtl && diagFunc == clkPkg::fnClrReset) mReset = 1'b0;
  if (diagLd && diagFunc == clkPkg::fnLdRate) mCfg.rateSel = ebusData[1:0];
  if (diagLd && diagFunc == clkPkg::fnLdEboxDis) begin
    {mCfg.crmDis, mCfg.edpDis, mCfg.ctlDis} = ebusData[2:0];
  end
  mRateDiv = mRateDiv + 3'd1;
endtask

/* sim/clkBoardTb.sv */
/* Self-checking testbench for the clock board: LFSR-driven commands and reads
   are compared each cycle against the included cycle model */
`timescale 1ns/1ps

module clkBoardTb;

  logic             CLK = 1'b0;
  logic             rstN;
  clkPkg::diagFuncT diagFunc;
  logic             diagCtl;
  logic             diagLd;
  logic             diagRead;
  clkPkg::diagDataT ebusData;
  clkPkg::cramTimeT cramTime;
  logic             clkTick;
  logic             eboxClk;
  logic             crmClk;
  logic             edpClk;
  logic             ctlClk;
  clkPkg::readWordT readData;
  logic             readValid;

  logic [31:0] lfsr;
  int          errorCount;
  int          checkCount;
  int          tickCount;
  int          eboxCount;
  int          ticksSinceEbox;
  int          expSpacing;
  string       testName;
  // Cycle budget per test, in run order
  int          testCycles [6] = '{5, 1300, 200, 400, 200, 250};

  `include "clkBoardModel.svh"

  clkBoard uut (.*);

  always #10 CLK = ~CLK;

  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      bits = {bits[30:0], lfsr[0]};
    end
    return bits;
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("CHECK FAILED %s %s: expected %0h, actual %0h at %0t",
               testName, what, expected, actual, $time);
    end
  endtask

  // Compare at the falling edge, step the model, then release strobes
  task automatic runCycle();
    logic expTick;
    @(negedge CLK);
    expTick = modelTick();
    checkValue("outputs", 32'({expTick, mClocks, mValid, mData}),
               32'({clkTick, eboxClk, crmClk, edpClk, ctlClk, readValid, readData}));
    if (eboxClk) begin
      if (expSpacing != 0) checkValue("ebox spacing", expSpacing, ticksSinceEbox);
      eboxCount++;
      ticksSinceEbox = 0;
    end
    if (clkTick) begin
      tickCount++;
      ticksSinceEbox++;
    end
    modelEdge();
    @(posedge CLK);
    #1;
    diagCtl = 1'b0;
    diagLd = 1'b0;
    diagRead = 1'b0;
  endtask

  task automatic idleCycles(input int count);
    repeat (count) runCycle();
  endtask

  task automatic sendControl(input clkPkg::diagFuncT func);
    diagFunc = func;
    diagCtl = 1'b1;
    runCycle();
  endtask

  task automatic loadRegister(input clkPkg::diagFuncT func, input clkPkg::diagDataT data);
    diagFunc = func;
    ebusData = data;
    diagLd = 1'b1;
    runCycle();
  endtask

  task automatic requestRead(input clkPkg::diagFuncT func);
    diagFunc = func;
    diagRead = 1'b1;
    runCycle();
  endtask

  // Wait for the tick or EBOX pulse count to reach a target
  task automatic waitEvents(input bit onEbox, input int target, input int limit);
    int waited;
    waited = 0;
    while ((onEbox ? eboxCount : tickCount) < target && waited < limit) begin
      runCycle();
      waited++;
    end
    if ((onEbox ? eboxCount : tickCount) < target) begin
      errorCount++;
      $display("ERROR: %s saw too few pulses within %0d cycles", testName, limit);
    end
  endtask

  task automatic afterResetTest();
    testName = "reset";
    repeat (2) @(posedge CLK);
    #1;
    rstN = 1'b1;
    modelReset();
    checkValue("outputs", 0, 32'({clkTick, eboxClk, crmClk, edpClk, ctlClk, readValid}));
    requestRead(clkPkg::rdEbox);
    checkValue("rdEbox", 32'(7'b1_100000), 32'({readValid, readData}));
  endtask

  task automatic burstTest();
    int burstLen;
    int startTicks;
    testName = "burst";
    for (int trial = 0; trial < 4; trial++) begin
      burstLen = takeBits(8);
      loadRegister(clkPkg::fnLdBurstLsb, 4'(burstLen));
      loadRegister(clkPkg::fnLdBurstMsb, 4'(burstLen >> 4));
      startTicks = tickCount;
      sendControl(clkPkg::fnBurst);
      waitEvents(1'b0, startTicks + burstLen, 300);
      idleCycles(4);
      checkValue("tick count", burstLen, tickCount - startTicks);
      requestRead(clkPkg::rdRun);
      checkValue("burst flag", 0, 32'(readData[0]));
    end
  endtask

  task automatic rateTest();
    int startTicks;
    testName = "rate";
    for (int rate = 0; rate < 4; rate++) begin
      loadRegister(clkPkg::fnLdRate, 4'(rate));
      sendControl(clkPkg::fnStart);
      startTicks = tickCount;
      idleCycles(16);
      checkValue("ticks in 16 cycles", 16 >> rate, tickCount - startTicks);
      sendControl(clkPkg::fnStop);
      startTicks = tickCount;
      idleCycles(8);
      checkValue("ticks after stop", 0, tickCount - startTicks);
      sendControl(clkPkg::fnSingleStep);
      waitEvents(1'b0, startTicks + 1, 10);
      idleCycles(8);
      checkValue("single step ticks", 1, tickCount - startTicks);
    end
  endtask

  task automatic eboxTest();
    int startEbox;
    testName = "ebox";
    loadRegister(clkPkg::fnLdRate, 4'd0);
    sendControl(clkPkg::fnStart);
    for (int trial = 0; trial < 8; trial++) begin
      // A pulse left over from the old cycle may land in the clear cycle
      expSpacing = 0;
      sendControl(clkPkg::fnSetReset);
      cramTime = 2'(takeBits(2));
      sendControl(clkPkg::fnClrReset);
      expSpacing = int'(cramTime) + 2;
      ticksSinceEbox = 0;
      waitEvents(1'b1, eboxCount + 4, 40);
    end
    expSpacing = 0;
    sendControl(clkPkg::fnSetReset);
    idleCycles(2);
    startEbox = eboxCount;
    idleCycles(20);
    checkValue("pulses in reset", 0, eboxCount - startEbox);
  endtask

  task automatic disableTest();
    testName = "disable";
    sendControl(clkPkg::fnClrReset);
    for (int trial = 0; trial < 6; trial++) begin
      loadRegister(clkPkg::fnLdEboxDis, 4'(takeBits(3)));
      waitEvents(1'b1, eboxCount + 2, 30);
    end
  endtask

  task automatic readbackTest();
    logic [1:0] op;
    testName = "readback";
    for (int i = 0; i < 200; i++) begin
      op = 2'(takeBits(2));
      case (op)
        2'd0, 2'd1: requestRead(3'(takeBits(3)));
        2'd2: loadRegister(takeBits(1) != 0 ? clkPkg::fnLdBurstMsb : clkPkg::fnLdBurstLsb,
                           4'(takeBits(4)));
        default: runCycle();
      endcase
    end
    for (int code = 3; code < 8; code++) begin
      requestRead(3'(code));
      checkValue("unused code", 0, 32'(readData));
    end
  endtask

  initial begin
    lfsr = 32'h706d_070f;
    errorCount = 0;
    checkCount = 0;
    tickCount = 0;
    eboxCount = 0;
    ticksSinceEbox = 0;
    expSpacing = 0;
    rstN = 1'b0;
    diagFunc = '0;
    diagCtl = 1'b0;
    diagLd = 1'b0;
    diagRead = 1'b0;
    ebusData = '0;
    cramTime = '0;
    afterResetTest();
    burstTest();
    rateTest();
    eboxTest();
    disableTest();
    readbackTest();
    $display("Summary: %0d errors in %0d checks", errorCount, checkCount);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int budget;
    budget = 200;
    foreach (testCycles[i]) budget += testCycles[i];
    #(budget * 20);
    $display("TIMEOUT: run did not finish within %0d cycles", budget);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* clkBoard.f */
+incdir+sim
source/clkPkg.sv
source/clkDiagFunc.sv
source/clkRunGate.sv
source/clkEboxCycle.sv
source/clkDiagRead.sv
source/clkBoard.sv
sim/clkBoardTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build the clock board testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f clkBoard.f --top-module clkBoardTb -o clkBoardSim; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/clkBoardSim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qxF -- ">>> PASS" <<< "$output"; then
  exit 0
fi

echo "Pass message not found"
exit 1
